//--- verilog/tlk_rx_pkg.sv
/*
 * Shared constants and the received word type for the TLK2711 receive path.
 * The RTL modules refer to these by scoped name.
 */
package tlk_rx_pkg;

    // sizes
    localparam int ADDR_WIDTH      = 32;
    localparam int DLEN_WIDTH      = 16;
    localparam int FIFO_DEPTH_LOG2 = 11;
    localparam int FIFO_DEPTH      = 1 << FIFO_DEPTH_LOG2;
    localparam int PAD_ALIGN_BYTES = 8;
    localparam logic [DLEN_WIDTH-1:0] PAD_ROUND = DLEN_WIDTH'(PAD_ALIGN_BYTES - 1);

    //////////////////////////////
    // 8b/10b control codes
    localparam logic [15:0] SYNC_WORD      = 16'hC5BC;
    localparam logic [15:0] SOF_WORD       = 16'h5CFB;
    localparam logic [15:0] EOF_WORD       = 16'hFDFE;
    localparam logic [15:0] LINK_LOSS_WORD = 16'hFFFF;

    // header flag, split over two words
    localparam logic [15:0] HEAD_FLAG_HI = 16'hEB90;
    localparam logic [15:0] HEAD_FLAG_LO = 16'hE116;

    // end-flag byte of the type word
    localparam logic [7:0] TAIL_FLAG = 8'd1;

    //////////////////////////////
    // framing states
    localparam int STATE_WIDTH = 4;
    localparam logic [STATE_WIDTH-1:0] ST_IDLE = 4'd0;
    localparam logic [STATE_WIDTH-1:0] ST_SYNC = 4'd1;
    localparam logic [STATE_WIDTH-1:0] ST_HEAD = 4'd2;
    localparam logic [STATE_WIDTH-1:0] ST_TYPE = 4'd3;
    localparam logic [STATE_WIDTH-1:0] ST_LINE = 4'd4;
    localparam logic [STATE_WIDTH-1:0] ST_LEN  = 4'd5;
    localparam logic [STATE_WIDTH-1:0] ST_RECV = 4'd6;
    localparam logic [STATE_WIDTH-1:0] ST_CHK  = 4'd7;
    localparam logic [STATE_WIDTH-1:0] ST_END  = 4'd8;

    // one link word, as a halfword or as two bytes (type word: mode, end flag)
    typedef union packed {
        logic [15:0] half;
        struct packed {
            logic [7:0] hi;
            logic [7:0] lo;
        } bytes;
    } tlk_word_u;

endpackage

//--- verilog/tlk_rx_fwft_fifo.sv
/*
 * First-word-fall-through FIFO for 16-bit payload words.
 * The head word is valid whenever o_empty is low; i_rd_en pops it.
 * Writes while full are dropped.
 */
`timescale 1ns/1ps

module tlk_rx_fwft_fifo (
    input  logic        clk,
    input  logic        rst,
    input  logic        i_wr_en,
    input  logic [15:0] i_wr_data,
    input  logic        i_rd_en,
    output logic [15:0] o_rd_data,
    output logic        o_empty,
    output logic        o_full
);

    logic [15:0]                            mem [0:tlk_rx_pkg::FIFO_DEPTH-1];
    logic [tlk_rx_pkg::FIFO_DEPTH_LOG2-1:0] wr_ptr;
    logic [tlk_rx_pkg::FIFO_DEPTH_LOG2-1:0] rd_ptr;
    logic [tlk_rx_pkg::FIFO_DEPTH_LOG2:0]   count;
    logic                                   do_wr;
    logic                                   do_rd;

    assign do_wr     = i_wr_en & ~o_full;
    assign do_rd     = i_rd_en & ~o_empty;
    assign o_empty   = (count == '0);
    assign o_full    = count[tlk_rx_pkg::FIFO_DEPTH_LOG2];
    assign o_rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- verilog/tlk_rx_frame_decoder.sv
/*
 * Framing FSM for the TLK2711 receive stream.
 * Captures the frame header, strobes out payload words one cycle late,
 * and flags sync-loss and link-loss words with a loss interrupt pulse.
 */
`timescale 1ns/1ps

module tlk_rx_frame_decoder (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              i_soft_rst,
    input  logic                              i_2711_rkmsb,
    input  logic                              i_2711_rklsb,
    input  tlk_rx_pkg::tlk_word_u             i_2711_rxd,
    output logic                              o_hdr_valid,
    output logic [tlk_rx_pkg::DLEN_WIDTH-1:0] o_frame_len,
    output logic                              o_tail_frame,
    output logic [15:0]                       o_line_num,
    output logic                              o_pay_valid,
    output tlk_rx_pkg::tlk_word_u             o_pay_data,
    output logic                              o_frame_end,
    output logic                              o_sync_loss,
    output logic                              o_link_loss,
    output logic                              o_loss_interrupt
);

    logic                               dec_rst;
    logic [tlk_rx_pkg::STATE_WIDTH-1:0] state;
    logic [tlk_rx_pkg::STATE_WIDTH-1:0] state_nxt;
    logic [15:0]                        prev_word;
    logic [tlk_rx_pkg::DLEN_WIDTH-2:0]  word_cnt;
    logic                               both_k;
    logic                               is_sync;
    logic                               is_sof;
    logic                               is_eof;
    logic                               is_head;
    logic                               last_word;
    logic                               is_sync_loss;
    logic                               is_link_loss;

    assign dec_rst = rst | i_soft_rst;
    assign both_k  = i_2711_rkmsb & i_2711_rklsb;

    // sync carries K only on the low byte
    assign is_sync = ~i_2711_rkmsb & i_2711_rklsb
                   & (i_2711_rxd.half == tlk_rx_pkg::SYNC_WORD);
    assign is_sof  = both_k & (i_2711_rxd.half == tlk_rx_pkg::SOF_WORD);
    assign is_eof  = both_k & (i_2711_rxd.half == tlk_rx_pkg::EOF_WORD);
    assign is_head = (prev_word == tlk_rx_pkg::HEAD_FLAG_HI)
                   & (i_2711_rxd.half == tlk_rx_pkg::HEAD_FLAG_LO);

    // length >= 2 bytes, so at least one payload word
    assign last_word = (word_cnt == o_frame_len[tlk_rx_pkg::DLEN_WIDTH-1:1] - 1'b1);

    assign is_sync_loss = ~i_2711_rkmsb & ~i_2711_rklsb
                        & (i_2711_rxd.half == tlk_rx_pkg::SYNC_WORD);
    assign is_link_loss = both_k & (i_2711_rxd.half == tlk_rx_pkg::LINK_LOSS_WORD);

    //////////////////////////////
    // framing FSM

    always_ff @(posedge clk) begin
        if (dec_rst) begin
            state <= tlk_rx_pkg::ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            tlk_rx_pkg::ST_IDLE: begin
                if (is_sync) begin
                    state_nxt = tlk_rx_pkg::ST_SYNC;
                end
            end
            tlk_rx_pkg::ST_SYNC: begin
                if (is_sof) begin
                    state_nxt = tlk_rx_pkg::ST_HEAD;
                end
            end
            tlk_rx_pkg::ST_HEAD: begin
                if (is_head) begin
                    state_nxt = tlk_rx_pkg::ST_TYPE;
                end
            end
            tlk_rx_pkg::ST_TYPE: state_nxt = tlk_rx_pkg::ST_LINE;
            tlk_rx_pkg::ST_LINE: state_nxt = tlk_rx_pkg::ST_LEN;
            tlk_rx_pkg::ST_LEN:  state_nxt = tlk_rx_pkg::ST_RECV;
            tlk_rx_pkg::ST_RECV: begin
                if (last_word) begin
                    state_nxt = tlk_rx_pkg::ST_CHK;
                end
            end
            // check word is passed over
            tlk_rx_pkg::ST_CHK:  state_nxt = tlk_rx_pkg::ST_END;
            tlk_rx_pkg::ST_END: begin
                if (is_eof) begin
                    state_nxt = tlk_rx_pkg::ST_IDLE;
                end
            end
            default: state_nxt = tlk_rx_pkg::ST_IDLE;
        endcase
    end

    //////////////////////////////
    // header and payload capture

    always_ff @(posedge clk) begin
        prev_word  <= i_2711_rxd.half;
        o_pay_data <= i_2711_rxd;
        if (state == tlk_rx_pkg::ST_TYPE) begin
            o_tail_frame <= (i_2711_rxd.bytes.lo == tlk_rx_pkg::TAIL_FLAG);
        end
        if (state == tlk_rx_pkg::ST_LINE) begin
            o_line_num <= i_2711_rxd.half;
        end
        if (state == tlk_rx_pkg::ST_LEN) begin
            o_frame_len <= i_2711_rxd.half;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_rst) begin
            o_hdr_valid <= 1'b0;
            o_pay_valid <= 1'b0;
            o_frame_end <= 1'b0;
            word_cnt    <= '0;
        end else begin
            // length register is loaded by the same edge
            o_hdr_valid <= (state == tlk_rx_pkg::ST_LEN);
            o_pay_valid <= (state == tlk_rx_pkg::ST_RECV);
            o_frame_end <= (state == tlk_rx_pkg::ST_END) & is_eof;
            if (state == tlk_rx_pkg::ST_RECV) begin
                word_cnt <= word_cnt + 1'b1;
            end else begin
                word_cnt <= '0;
            end
        end
    end

    //////////////////////////////
    // loss detection

    // flag, then interrupt, then both clear
    always_ff @(posedge clk) begin
        if (dec_rst) begin
            o_sync_loss      <= 1'b0;
            o_link_loss      <= 1'b0;
            o_loss_interrupt <= 1'b0;
        end else begin
            if (is_sync_loss) begin
                o_sync_loss <= 1'b1;
            end else if (o_loss_interrupt) begin
                o_sync_loss <= 1'b0;
            end
            if (is_link_loss) begin
                o_link_loss <= 1'b1;
            end else if (o_loss_interrupt) begin
                o_link_loss <= 1'b0;
            end
            o_loss_interrupt <= ~o_loss_interrupt & (o_sync_loss | o_link_loss);
        end
    end

endmodule

//--- verilog/tlk_rx_dma_ctrl.sv
/*
 * DMA write side of the receive path. Issues one command per frame with
 * the length rounded up to 8 bytes, forwards payload words to the FIFO
 * with zero pads, steps the write address and keeps frame statistics.
 */
`timescale 1ns/1ps

module tlk_rx_dma_ctrl (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              i_hdr_valid,
    input  logic [tlk_rx_pkg::DLEN_WIDTH-1:0] i_frame_len,
    input  logic                              i_tail_frame,
    input  logic                              i_pay_valid,
    input  tlk_rx_pkg::tlk_word_u             i_pay_data,
    input  logic                              i_frame_end,
    input  logic                              i_wr_cmd_ack,
    input  logic                              i_rx_start,
    input  logic [tlk_rx_pkg::ADDR_WIDTH-1:0] i_rx_base_addr,
    input  logic                              i_wr_finish,
    output logic                              o_wr_cmd_req,
    output logic [tlk_rx_pkg::ADDR_WIDTH-1:0] o_wr_cmd_addr,
    output logic [tlk_rx_pkg::DLEN_WIDTH-1:0] o_wr_cmd_len,
    output logic                              o_fifo_wr_en,
    output logic [15:0]                       o_fifo_wr_data,
    output logic                              o_rx_interrupt,
    output logic [31:0]                       o_rx_total_packet,
    output logic [15:0]                       o_rx_packet_tail,
    output logic [15:0]                       o_rx_body_num
);

    logic [tlk_rx_pkg::DLEN_WIDTH-1:0] round_len;
    logic [tlk_rx_pkg::DLEN_WIDTH-1:0] pad_bytes;
    logic [tlk_rx_pkg::DLEN_WIDTH-1:0] valid_len;
    logic [tlk_rx_pkg::ADDR_WIDTH-1:0] wr_addr;
    logic [tlk_rx_pkg::DLEN_WIDTH-2:0] pay_left;
    logic [1:0]                        pad_left;
    logic                              last_pay;
    logic                              tail_ack;
    logic                              tail_pending;
    logic                              tail_seen;

    assign round_len = (i_frame_len + tlk_rx_pkg::PAD_ROUND) & ~tlk_rx_pkg::PAD_ROUND;
    assign pad_bytes = o_wr_cmd_len - valid_len;
    assign last_pay  = i_pay_valid & (pay_left == 1);
    assign tail_ack  = tail_pending & o_wr_cmd_req & i_wr_cmd_ack;

    assign o_rx_interrupt = tail_seen & i_wr_finish;

    //////////////////////////////
    // command and FIFO write

    always_ff @(posedge clk) begin
        if (i_hdr_valid) begin
            o_wr_cmd_len  <= round_len;
            o_wr_cmd_addr <= wr_addr;
            valid_len     <= i_frame_len;
        end
        // zero when no payload, which is the pad word
        o_fifo_wr_data <= i_pay_valid ? i_pay_data.half : 16'h0000;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_wr_cmd_req <= 1'b0;
            o_fifo_wr_en <= 1'b0;
            pay_left     <= '0;
            pad_left     <= '0;
            wr_addr      <= '0;
            tail_pending <= 1'b0;
        end else begin
            if (i_hdr_valid) begin
                o_wr_cmd_req <= 1'b1;
            end else if (i_wr_cmd_ack) begin
                o_wr_cmd_req <= 1'b0;
            end

            o_fifo_wr_en <= i_pay_valid | (pad_left != 0);

            if (i_hdr_valid) begin
                pay_left <= i_frame_len[tlk_rx_pkg::DLEN_WIDTH-1:1];
            end else if (i_pay_valid && pay_left != 0) begin
                pay_left <= pay_left - 1'b1;
            end

            // pads follow the last payload word back to back
            if (last_pay) begin
                pad_left <= pad_bytes[2:1];
            end else if (pad_left != 0) begin
                pad_left <= pad_left - 1'b1;
            end

            if (i_rx_start) begin
                wr_addr <= i_rx_base_addr;
            end else if (i_frame_end) begin
                wr_addr <= wr_addr + tlk_rx_pkg::ADDR_WIDTH'(o_wr_cmd_len);
            end

            if (i_hdr_valid) begin
                tail_pending <= i_tail_frame;
            end
        end
    end

    //////////////////////////////
    // statistics

    always_ff @(posedge clk) begin
        if (rst) begin
            o_rx_body_num     <= '0;
            o_rx_total_packet <= '0;
            o_rx_packet_tail  <= '0;
            tail_seen         <= 1'b0;
        end else begin
            if (i_rx_start) begin
                o_rx_body_num     <= '0;
                o_rx_total_packet <= '0;
                o_rx_packet_tail  <= '0;
            end else begin
                if (i_frame_end) begin
                    o_rx_body_num     <= o_rx_body_num + 1'b1;
                    o_rx_total_packet <= o_rx_total_packet + 32'(valid_len);
                end
                if (tail_ack) begin
                    o_rx_packet_tail <= valid_len;
                end
            end

            // held until the DMA reports the tail write done
            if (tail_ack) begin
                tail_seen <= 1'b1;
            end else if (i_wr_finish) begin
                tail_seen <= 1'b0;
            end
        end
    end

endmodule

//--- verilog/tlk_rx_link.sv
/*
 * Top level of the TLK2711 receive link. Connects the frame decoder,
 * the DMA controller and the payload FIFO; the DMA side pops the FIFO
 * whenever it is ready and data is present.
 */
`timescale 1ns/1ps

module tlk_rx_link (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              i_soft_rst,
    input  logic                              i_2711_rkmsb,
    input  logic                              i_2711_rklsb,
    input  logic [15:0]                       i_2711_rxd,
    input  logic                              i_wr_cmd_ack,
    output logic                              o_wr_cmd_req,
    output logic [tlk_rx_pkg::ADDR_WIDTH-1:0] o_wr_cmd_addr,
    output logic [tlk_rx_pkg::DLEN_WIDTH-1:0] o_wr_cmd_len,
    input  logic                              i_rx_start,
    input  logic [tlk_rx_pkg::ADDR_WIDTH-1:0] i_rx_base_addr,
    input  logic                              i_dma_wr_ready,
    input  logic                              i_wr_finish,
    output logic                              o_dma_wr_valid,
    output logic [15:0]                       o_dma_wr_data,
    output logic                              o_rx_interrupt,
    output logic [31:0]                       o_rx_total_packet,
    output logic [15:0]                       o_rx_packet_tail,
    output logic [15:0]                       o_rx_body_num,
    output logic                              o_loss_interrupt,
    output logic                              o_sync_loss,
    output logic                              o_link_loss
);

    logic                              hdr_valid;
    logic [tlk_rx_pkg::DLEN_WIDTH-1:0] frame_len;
    logic                              tail_frame;
    logic                              pay_valid;
    logic                              pay_valid_gated;
    tlk_rx_pkg::tlk_word_u             pay_data;
    logic                              frame_end;
    logic                              fifo_wr_en;
    logic [15:0]                       fifo_wr_data;
    logic                              fifo_empty;
    logic                              fifo_rst;

    assign fifo_rst = rst | i_soft_rst;

    // a word in flight at soft reset belongs to the dropped frame
    assign pay_valid_gated = pay_valid & ~i_soft_rst;

    assign o_dma_wr_valid = ~fifo_empty & i_dma_wr_ready;

    tlk_rx_frame_decoder u_decoder (
        .clk              (clk),
        .rst              (rst),
        .i_soft_rst       (i_soft_rst),
        .i_2711_rkmsb     (i_2711_rkmsb),
        .i_2711_rklsb     (i_2711_rklsb),
        .i_2711_rxd       (i_2711_rxd),
        .o_hdr_valid      (hdr_valid),
        .o_frame_len      (frame_len),
        .o_tail_frame     (tail_frame),
        .o_line_num       (),
        .o_pay_valid      (pay_valid),
        .o_pay_data       (pay_data),
        .o_frame_end      (frame_end),
        .o_sync_loss      (o_sync_loss),
        .o_link_loss      (o_link_loss),
        .o_loss_interrupt (o_loss_interrupt)
    );

    tlk_rx_dma_ctrl u_dma_ctrl (
        .clk               (clk),
        .rst               (rst),
        .i_hdr_valid       (hdr_valid),
        .i_frame_len       (frame_len),
        .i_tail_frame      (tail_frame),
        .i_pay_valid       (pay_valid_gated),
        .i_pay_data        (pay_data),
        .i_frame_end       (frame_end),
        .i_wr_cmd_ack      (i_wr_cmd_ack),
        .i_rx_start        (i_rx_start),
        .i_rx_base_addr    (i_rx_base_addr),
        .i_wr_finish       (i_wr_finish),
        .o_wr_cmd_req      (o_wr_cmd_req),
        .o_wr_cmd_addr     (o_wr_cmd_addr),
        .o_wr_cmd_len      (o_wr_cmd_len),
        .o_fifo_wr_en      (fifo_wr_en),
        .o_fifo_wr_data    (fifo_wr_data),
        .o_rx_interrupt    (o_rx_interrupt),
        .o_rx_total_packet (o_rx_total_packet),
        .o_rx_packet_tail  (o_rx_packet_tail),
        .o_rx_body_num     (o_rx_body_num)
    );

    tlk_rx_fwft_fifo u_fifo (
        .clk       (clk),
        .rst       (fifo_rst),
        .i_wr_en   (fifo_wr_en),
        .i_wr_data (fifo_wr_data),
        .i_rd_en   (o_dma_wr_valid),
        .o_rd_data (o_dma_wr_data),
        .o_empty   (fifo_empty),
        .o_full    ()
    );

endmodule

//--- test/tlk_rx_frame_tasks.svh
/*
 * Stimulus and wait tasks for the TLK2711 receive testbench.
 * Drives link words and whole frames, and waits on DUT outputs
 * with a timeout. Included inside the testbench module.
 */
`ifndef TLK_RX_FRAME_TASKS_SVH
`define TLK_RX_FRAME_TASKS_SVH

localparam int WAIT_LIMIT = 2000;

// payload word i of a frame, built from its line number
function automatic logic [15:0] payload_word(input logic [15:0] line, input int idx);
    return {line[7:0], 8'(idx)};
endfunction

task automatic drive_word(input logic k_msb, input logic k_lsb, input logic [15:0] data);
    @(posedge clk);
    i_2711_rkmsb <= k_msb;
    i_2711_rklsb <= k_lsb;
    i_2711_rxd   <= data;
endtask

task automatic drive_idle(input int n);
    repeat (n) drive_word(1'b0, 1'b1, tlk_rx_pkg::SYNC_WORD);
endtask

// a short n_send leaves the frame open, with no check word and no EOF
task automatic drive_frame(input logic [7:0] mode, input logic tail, input logic [15:0] line,
                           input logic [15:0] len, input int n_send);
    logic [15:0] chk;
    int          i;
    chk = '0;
    drive_idle(2);
    drive_word(1'b1, 1'b1, tlk_rx_pkg::SOF_WORD);
    drive_word(1'b0, 1'b0, tlk_rx_pkg::HEAD_FLAG_HI);
    drive_word(1'b0, 1'b0, tlk_rx_pkg::HEAD_FLAG_LO);
    drive_word(1'b0, 1'b0, {mode, 7'd0, tail});
    drive_word(1'b0, 1'b0, line);
    drive_word(1'b0, 1'b0, len);
    for (i = 0; i < n_send; i++) begin
        drive_word(1'b0, 1'b0, payload_word(line, i));
        chk = chk ^ payload_word(line, i);
    end
    if (n_send == len / 2) begin
        drive_word(1'b0, 1'b0, chk);
        drive_word(1'b1, 1'b1, tlk_rx_pkg::EOF_WORD);
        drive_idle(4);
    end
endtask

task automatic await_cmd_req();
    int n;
    n = 0;
    @(negedge clk);
    while (o_wr_cmd_req !== 1'b1) begin
        if (n == WAIT_LIMIT) begin
            abort_run("timed out waiting for a DMA write command request");
        end
        n++;
        @(negedge clk);
    end
endtask

task automatic await_words(input int n_words);
    int n;
    n = 0;
    while (rx_words.size() < n_words) begin
        if (n == WAIT_LIMIT) begin
            abort_run("timed out waiting for DMA write data words");
        end
        n++;
        @(negedge clk);
    end
endtask

task automatic await_loss_flag(input logic link);
    int n;
    n = 0;
    @(negedge clk);
    while ((link ? o_link_loss : o_sync_loss) !== 1'b1) begin
        if (n == WAIT_LIMIT) begin
            abort_run("timed out waiting for a loss status flag");
        end
        n++;
        @(negedge clk);
    end
endtask

`endif

//--- test/tlk_rx_link_tb.sv
/*
 * Testbench for the TLK2711 receive link. Applies a table of frames,
 * models the DMA side with random acknowledge delay and back-pressure,
 * and checks commands, data, statistics, interrupts and loss flags.
 */
`timescale 1ns/1ps

module tlk_rx_link_tb;

    localparam logic [31:0] BASE_ADDR  = 32'h8000_0100;
    localparam int          NUM_FRAMES = 6;

    logic        clk;
    logic        rst;
    logic        i_soft_rst;
    logic        i_2711_rkmsb;
    logic        i_2711_rklsb;
    logic [15:0] i_2711_rxd;
    logic        i_wr_cmd_ack;
    logic        o_wr_cmd_req;
    logic [31:0] o_wr_cmd_addr;
    logic [15:0] o_wr_cmd_len;
    logic        i_rx_start;
    logic [31:0] i_rx_base_addr;
    logic        i_dma_wr_ready;
    logic        i_wr_finish;
    logic        o_dma_wr_valid;
    logic [15:0] o_dma_wr_data;
    logic        o_rx_interrupt;
    logic [31:0] o_rx_total_packet;
    logic [15:0] o_rx_packet_tail;
    logic [15:0] o_rx_body_num;
    logic        o_loss_interrupt;
    logic        o_sync_loss;
    logic        o_link_loss;

    int          seed = 4214;
    int          err_count = 0;
    int          test_count = 0;
    int          fail_count = 0;
    int          irq_count = 0;
    int          n_tails = 0;
    logic [31:0] exp_addr;
    logic [31:0] exp_total;
    logic [15:0] exp_tail;
    logic [15:0] exp_frames;
    logic [15:0] rx_words [$];
    // mode, end flag, line, byte length, padded length
    logic [63:0] frame_table [0:NUM_FRAMES];

    tlk_rx_link dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // random back-pressure from the DMA side
    initial begin
        i_dma_wr_ready = 1'b0;
        forever begin
            @(posedge clk);
            i_dma_wr_ready <= ({$random(seed)} % 4) != 0;
        end
    end

    always @(negedge clk) begin
        if (o_dma_wr_valid === 1'b1) begin
            rx_words.push_back(o_dma_wr_data);
        end
        if (o_rx_interrupt === 1'b1) begin
            irq_count++;
        end
    end

    task automatic abort_run(input string what);
        $display("%s at %0t ns", what, $time);
        $display("FAIL: see errors above");
        $finish;
    endtask

    task automatic flag_error(input string msg);
        err_count++;
        $display("FAILED t=%0t ns: %s", $time, msg);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_count++;
        if (err_count != errs_before) begin
            fail_count++;
            $display("test %0d %s: failed", test_count, name);
        end else begin
            $display("test %0d %s: ok", test_count, name);
        end
    endtask

    `include "tlk_rx_frame_tasks.svh"

    task automatic ack_command();
        repeat ({$random(seed)} % 6) @(posedge clk);
        @(posedge clk);
        i_wr_cmd_ack <= 1'b1;
        @(posedge clk);
        i_wr_cmd_ack <= 1'b0;
    endtask

    //////////////////////////////
    // DMA side of one frame
    task automatic serve_dma(input logic [15:0] plen, input logic tail);
        await_cmd_req();
        if (o_wr_cmd_addr !== exp_addr) begin
            flag_error($sformatf("command address %0h, expected %0h", o_wr_cmd_addr, exp_addr));
        end
        if (o_wr_cmd_len !== plen) begin
            flag_error($sformatf("command length %0d, expected %0d", o_wr_cmd_len, plen));
        end
        ack_command();
        await_words(plen / 2);
        @(posedge clk);
        i_wr_finish <= 1'b1;
        @(negedge clk);
        if (o_rx_interrupt !== tail) begin
            flag_error($sformatf("rx interrupt %b at write finish, expected %b",
                                 o_rx_interrupt, tail));
        end
        @(posedge clk);
        i_wr_finish <= 1'b0;
    endtask

    task automatic run_frame(input int idx);
        logic [63:0] entry;
        logic [15:0] line;
        logic [15:0] len;
        logic [15:0] plen;
        logic [15:0] expected;
        logic        tail;
        int          errs_before;
        int          i;
        entry = frame_table[idx];
        tail  = entry[48];
        line  = entry[47:32];
        len   = entry[31:16];
        plen  = entry[15:0];
        errs_before = err_count;
        rx_words.delete();
        fork
            drive_frame(entry[63:56], tail, line, len, len / 2);
            serve_dma(plen, tail);
        join
        if (rx_words.size() != plen / 2) begin
            flag_error($sformatf("%0d data words, expected %0d", rx_words.size(), plen / 2));
        end
        for (i = 0; i < rx_words.size() && i < plen / 2; i++) begin
            // payload first, then zero pads
            expected = (i < len / 2) ? payload_word(line, i) : 16'h0000;
            if (rx_words[i] !== expected) begin
                flag_error($sformatf("data word %0d is %h, expected %h", i, rx_words[i], expected));
            end
        end
        exp_addr   = exp_addr + plen;
        exp_total  = exp_total + len;
        exp_frames = exp_frames + 1'b1;
        if (tail) begin
            exp_tail = len;
            n_tails++;
        end
        finish_test($sformatf("frame line %h", line), errs_before);
    endtask

    task automatic check_loss(input logic link);
        int errs_before;
        int pulses;
        int i;
        errs_before = err_count;
        pulses = 0;
        if (link) begin
            drive_word(1'b1, 1'b1, tlk_rx_pkg::LINK_LOSS_WORD);
        end else begin
            drive_word(1'b0, 1'b0, tlk_rx_pkg::SYNC_WORD);
        end
        drive_idle(1);
        await_loss_flag(link);
        if ((link ? o_sync_loss : o_link_loss) !== 1'b0) begin
            flag_error("the other loss flag is set");
        end
        for (i = 0; i < 6; i++) begin
            @(negedge clk);
            if (o_loss_interrupt === 1'b1) begin
                pulses++;
            end
        end
        if (pulses != 1) begin
            flag_error($sformatf("%0d loss interrupt pulses, expected 1", pulses));
        end
        if (o_sync_loss !== 1'b0 || o_link_loss !== 1'b0) begin
            flag_error("loss flag still set after the interrupt");
        end
        finish_test(link ? "link loss" : "sync loss", errs_before);
    endtask

    initial begin
        int errs_before;
        int k;
        frame_table[0] = {8'h01, 8'h00, 16'h0011, 16'd2,  16'd8};
        frame_table[1] = {8'h01, 8'h00, 16'h0012, 16'd8,  16'd8};
        frame_table[2] = {8'h02, 8'h01, 16'h0013, 16'd14, 16'd16};
        frame_table[3] = {8'h01, 8'h00, 16'h0014, 16'd22, 16'd24};
        frame_table[4] = {8'h02, 8'h00, 16'h0015, 16'd36, 16'd40};
        frame_table[5] = {8'h03, 8'h01, 16'h0016, 16'd60, 16'd64};
        // frame after the soft reset
        frame_table[6] = {8'h01, 8'h00, 16'h0021, 16'd10, 16'd16};

        rst            = 1'b1;
        i_soft_rst     = 1'b0;
        i_2711_rkmsb   = 1'b0;
        i_2711_rklsb   = 1'b1;
        i_2711_rxd     = tlk_rx_pkg::SYNC_WORD;
        i_wr_cmd_ack   = 1'b0;
        i_rx_start     = 1'b0;
        i_rx_base_addr = '0;
        i_wr_finish    = 1'b0;
        exp_addr   = BASE_ADDR;
        exp_total  = '0;
        exp_tail   = '0;
        exp_frames = '0;

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        i_rx_start     <= 1'b1;
        i_rx_base_addr <= BASE_ADDR;
        @(posedge clk);
        i_rx_start <= 1'b0;
        drive_idle(4);

        check_loss(1'b0);
        check_loss(1'b1);

        for (k = 0; k < NUM_FRAMES; k++) begin
            run_frame(k);
        end

        //////////////////////////////
        // soft reset part way through the payload
        errs_before = err_count;
        drive_frame(8'h01, 1'b0, 16'h0020, 16'd40, 3);
        @(posedge clk);
        i_soft_rst   <= 1'b1;
        i_2711_rkmsb <= 1'b0;
        i_2711_rklsb <= 1'b1;
        i_2711_rxd   <= tlk_rx_pkg::SYNC_WORD;
        @(posedge clk);
        i_soft_rst <= 1'b0;
        rx_words.delete();
        await_cmd_req();
        if (o_wr_cmd_addr !== exp_addr) begin
            flag_error($sformatf("aborted frame address %0h, expected %0h", o_wr_cmd_addr, exp_addr));
        end
        ack_command();
        drive_idle(12);
        if (rx_words.size() != 0) begin
            flag_error($sformatf("%0d data words after soft reset", rx_words.size()));
        end
        finish_test("soft reset", errs_before);
        run_frame(NUM_FRAMES);

        errs_before = err_count;
        if (o_rx_body_num !== exp_frames) begin
            flag_error($sformatf("frame count %0d, expected %0d", o_rx_body_num, exp_frames));
        end
        if (o_rx_total_packet !== exp_total) begin
            flag_error($sformatf("byte total %0d, expected %0d", o_rx_total_packet, exp_total));
        end
        if (o_rx_packet_tail !== exp_tail) begin
            flag_error($sformatf("tail length %0d, expected %0d", o_rx_packet_tail, exp_tail));
        end
        if (irq_count != n_tails) begin
            flag_error($sformatf("%0d rx interrupts, expected %0d", irq_count, n_tails));
        end
        finish_test("statistics", errs_before);

        errs_before = err_count;
        @(posedge clk);
        i_rx_start <= 1'b1;
        @(posedge clk);
        i_rx_start <= 1'b0;
        @(negedge clk);
        if (o_rx_body_num !== 16'd0 || o_rx_total_packet !== 32'd0 || o_rx_packet_tail !== 16'd0) begin
            flag_error("statistics not cleared by rx start");
        end
        finish_test("statistics clear", errs_before);

        $display("tests run %0d, tests failed %0d, errors %0d", test_count, fail_count, err_count);
        if (err_count == 0 && fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+test
verilog/tlk_rx_pkg.sv
verilog/tlk_rx_fwft_fifo.sv
verilog/tlk_rx_frame_decoder.sv
verilog/tlk_rx_dma_ctrl.sv
verilog/tlk_rx_link.sv
test/tlk_rx_link_tb.sv

//--- Bender.yml
package:
  name: tlk_rx_link

sources:
  - verilog/tlk_rx_pkg.sv
  - verilog/tlk_rx_fwft_fifo.sv
  - verilog/tlk_rx_frame_decoder.sv
  - verilog/tlk_rx_dma_ctrl.sv
  - verilog/tlk_rx_link.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tlk_rx_link_tb.sv
